/* tb.f */
verilog/cpu_pkg.sv
verilog/alu.sv
verilog/reg_file.sv
verilog/bus_arbiter.sv
verilog/fetch_unit.sv
verilog/exec_unit.sv
verilog/cpu_top.sv
tests/cpu_bus_assert.sv
tests/tb_cpu.sv

/* run_sim.sh */
#!/bin/sh
# Build the core testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f tb.f --top-module tb_cpu -o tb_cpu_sim
./obj_dir/tb_cpu_sim | tee sim.log
if grep -q "ALL CHECKS PASSED" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

/* tests/tb_cpu.sv */
/*
 * Testbench for the core. A 256-word memory model with random back-pressure
 * runs one short program per table row and per random case, then compares
 * the stored words with a reference model.
 */
`timescale 1ns/10ps
`default_nettype none

module tb_cpu
    import cpu_pkg::*;
;

    localparam logic [31:0] SEED         = 32'h8e7c_a89d;
    localparam int          HALT_TIMEOUT = 2000;    // Cycles per program
    localparam int          NUM_CASES    = 10;
    localparam int          NUM_RANDOM   = 8;

    typedef struct packed {
        opcode_e     op;
        logic [11:0] a;        // Operand loaded into r1
        logic [11:0] b;        // Operand loaded into r2
        logic        taken;    // bne should branch
        logic        use_r0;   // First operand goes to r0
    } case_t;

    localparam case_t CASES [NUM_CASES] = '{
        '{OP_ADD, 12'h123, 12'h456, 1'b0, 1'b0},
        '{OP_SUB, 12'h010, 12'h7ff, 1'b0, 1'b0},    // Wraps below zero
        '{OP_SUB, 12'h800, 12'h001, 1'b0, 1'b0},
        '{OP_AND, 12'hf0f, 12'h3c3, 1'b0, 1'b0},
        '{OP_OR,  12'h0a5, 12'h50a, 1'b0, 1'b0},
        '{OP_ADD, 12'h321, 12'h0bc, 1'b0, 1'b1},    // r0 write dropped
        '{OP_LW,  12'h2aa, 12'h155, 1'b0, 1'b0},
        '{OP_BNE, 12'h111, 12'h222, 1'b1, 1'b0},
        '{OP_BNE, 12'h333, 12'h333, 1'b0, 1'b0},
        '{OP_J,   12'h100, 12'h023, 1'b0, 1'b0}
    };
    localparam opcode_e ALU_OPS [4] = '{OP_ADD, OP_SUB, OP_AND, OP_OR};

    logic        clock;
    logic        rst_n = 1'b0;
    logic        mem_req_valid;
    mem_req_t    mem_req;
    logic        mem_req_ready = 1'b0;
    logic        mem_rsp_valid = 1'b0;
    mem_rsp_t    mem_rsp = '0;
    logic        halted;
    logic [31:0] mem [256];
    logic [31:0] image [256];           // Program loaded during reset
    logic [31:0] rdy_lcg = SEED;
    logic [31:0] op_lcg;
    int unsigned req_count = 0;         // Accepted bus requests

    cpu_top #(.RESET_PC(32'h0), .NUM_REGS(32)) dut (
        .clock, .rst_n, .mem_req_valid, .mem_req, .mem_req_ready,
        .mem_rsp_valid, .mem_rsp, .halted
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    function automatic logic [31:0] next_lcg(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // ------------------------------------------------------------------------
    // Memory model with a one-cycle response and ready low on about one cycle in four
    // ------------------------------------------------------------------------
    always @(posedge clock) begin
        rdy_lcg       <= next_lcg(rdy_lcg);
        mem_req_ready <= rdy_lcg[31] | rdy_lcg[30];
        if (!rst_n) begin
            mem_rsp_valid <= 1'b0;
            for (int i = 0; i < 256; i++) begin
                mem[i] <= image[i];
            end
        end else begin
            mem_rsp_valid <= mem_req_valid & mem_req_ready;
            if (mem_req_valid && mem_req_ready) begin
                mem_rsp   <= '{rdata: mem[mem_req.addr[7:0]]};
                req_count <= req_count + 1;
                if (mem_req.we) begin
                    mem[mem_req.addr[7:0]] <= mem_req.wdata;
                end
            end
        end
    end

    // Instruction encoders
    function automatic logic [31:0] r_type(input opcode_e op, input logic [4:0] rd,
                                           input logic [4:0] rs, input logic [4:0] rt);
        return {op, rd, rs, rt, 12'h000};
    endfunction

    function automatic logic [31:0] i_type(input opcode_e op, input logic [4:0] rd,
                                           input logic [4:0] rs, input logic [16:0] imm);
        return {op, rd, rs, imm};
    endfunction

    // Reference model for the value each program leaves in word 200
    function automatic logic [31:0] expected_word(input case_t tc);
        logic [31:0] a;
        logic [31:0] b;
        a = {{20{tc.a[11]}}, tc.a};
        b = {{20{tc.b[11]}}, tc.b};
        case (tc.op)
            OP_ADD:  return tc.use_r0 ? b : a + b;    // r0 stays zero
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_BNE:  return tc.taken ? 32'd1 : 32'd2; // Path marker
            default: return a + b;                    // lw and j store the sum
        endcase
    endfunction

    task automatic build_program(input case_t tc);
        logic [31:0] sw_200;
        logic [31:0] halt_word;
        sw_200    = i_type(OP_SW, 5'd3, 5'd0, 17'd200);
        halt_word = {OP_HALT, 27'd0};
        for (int i = 0; i < 256; i++) begin
            image[i] = {16'h5a5a, 8'(i), 8'(255 - i)};   // Runs as a nop
        end
        image[0] = i_type(OP_ADDI, tc.use_r0 ? 5'd0 : 5'd1, 5'd0, {{5{tc.a[11]}}, tc.a});
        image[1] = i_type(OP_ADDI, 5'd2, 5'd0, {{5{tc.b[11]}}, tc.b});
        case (tc.op)
            OP_LW: begin
                image[2] = r_type(OP_ADD, 5'd3, 5'd1, 5'd2);
                image[3] = sw_200;
                image[4] = i_type(OP_LW, 5'd4, 5'd0, 17'd200);
                image[5] = i_type(OP_SW, 5'd4, 5'd0, 17'd201);
                image[6] = halt_word;
            end
            OP_BNE: begin
                image[2] = i_type(OP_ADDI, 5'd3, 5'd0, 17'd1);   // Taken marker
                image[3] = i_type(OP_BNE, 5'd1, 5'd2, 17'd1);    // To word 5
                image[4] = i_type(OP_ADDI, 5'd3, 5'd0, 17'd2);   // Fall-through marker
                image[5] = sw_200;
                image[6] = halt_word;
            end
            OP_J: begin
                image[2] = r_type(OP_ADD, 5'd3, 5'd1, 5'd2);
                image[3] = {OP_J, 27'd5};
                image[4] = i_type(OP_ADDI, 5'd3, 5'd3, 17'd1);   // Must be skipped
                image[5] = sw_200;
                image[6] = halt_word;
            end
            default: begin
                image[2] = r_type(tc.op, 5'd3, tc.use_r0 ? 5'd0 : 5'd1, 5'd2);
                image[3] = sw_200;
                image[4] = halt_word;
            end
        endcase
    endtask

    task automatic stop_run();
        $display("CHECKS FAILED");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("Error at time %0t: %s is %h, expected %h", $time, what, got, exp);
            stop_run();
        end
    endtask

    task automatic wait_for_halt();
        int cycles;
        cycles = 0;
        while (!halted && cycles < HALT_TIMEOUT) begin
            @(negedge clock);
            cycles++;
        end
        if (!halted) begin
            $display("Timeout: the core did not halt within %0d cycles", HALT_TIMEOUT);
            stop_run();
        end
    endtask

    task automatic run_case(input case_t tc);
        int unsigned reqs_at_halt;
        build_program(tc);
        @(posedge clock);
        rst_n <= 1'b0;
        repeat (8) @(posedge clock);
        rst_n <= 1'b1;
        wait_for_halt();
        check_value(mem[200], expected_word(tc), "word 200");
        if (tc.op == OP_LW) begin
            check_value(mem[201], expected_word(tc), "word 201 after lw");
        end
        reqs_at_halt = req_count;
        repeat (10) @(negedge clock);                     // Bus must stay quiet
        check_value(req_count, reqs_at_halt, "bus requests after halt");
    endtask

    initial begin
        case_t tc;
        op_lcg = SEED;
        for (int i = 0; i < NUM_CASES; i++) begin
            run_case(CASES[i]);
        end
        for (int i = 0; i < NUM_RANDOM; i++) begin
            op_lcg    = next_lcg(op_lcg);
            tc.a      = op_lcg[31:20];
            op_lcg    = next_lcg(op_lcg);
            tc.b      = op_lcg[31:20];
            op_lcg    = next_lcg(op_lcg);
            tc.op     = ALU_OPS[op_lcg[31:30]];
            tc.taken  = 1'b0;
            tc.use_r0 = 1'b0;
            run_case(tc);
        end
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* tests/cpu_bus_assert.sv */
/*
 * Concurrent checks on the external memory bus of the core, bound into
 * cpu_top. Covers request hold under back-pressure, the single outstanding
 * access and a quiet bus after halt.
 */
`timescale 1ns/10ps
`default_nettype none

module cpu_bus_assert
    import cpu_pkg::*;
(
    input wire            clock,
    input wire            rst_n,
    input wire            mem_req_valid,
    input wire mem_req_t  mem_req,
    input wire            mem_req_ready,
    input wire            mem_rsp_valid,
    input wire            halted
);

    logic pending;     // Accepted request, response not seen yet

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            pending <= 1'b0;
        end else if (mem_req_valid && mem_req_ready) begin
            pending <= 1'b1;
        end else if (mem_rsp_valid) begin
            pending <= 1'b0;
        end
    end

    // Stalled request keeps valid and payload
    req_held: assert property (@(posedge clock) disable iff (!rst_n)
        mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req))
        else $error("Bus request changed while stalled");

    no_req_halted: assert property (@(posedge clock) disable iff (!rst_n)
        halted |-> !mem_req_valid)
        else $error("Bus request issued after halt");

    one_outstanding: assert property (@(posedge clock) disable iff (!rst_n)
        pending |-> !mem_req_valid)
        else $error("Bus request issued while a response is outstanding");

endmodule

bind cpu_top cpu_bus_assert u_bus_assert (
    .clock         (clock),
    .rst_n         (rst_n),
    .mem_req_valid (mem_req_valid),
    .mem_req       (mem_req),
    .mem_req_ready (mem_req_ready),
    .mem_rsp_valid (mem_rsp_valid),
    .halted        (halted)
);

`default_nettype wire

/* verilog/cpu_top.sv */
/*
 * Top level of the core. Connects fetch, execute, the register file and the
 * bus arbiter, and brings the shared memory bus and halted out to the ports.
 */
`timescale 1ns/10ps
`default_nettype none

module cpu_top
    import cpu_pkg::*;
#(
    parameter logic [DATA_W-1:0] RESET_PC = '0,
    parameter int                NUM_REGS = 32
) (
    input  wire            clock,
    input  wire            rst_n,
    output logic           mem_req_valid,
    output mem_req_t       mem_req,
    input  wire            mem_req_ready,
    input  wire            mem_rsp_valid,
    input  wire mem_rsp_t  mem_rsp,
    output logic           halted
);

    // ------------------------------------------------------------------------
    // Internal channels
    // ------------------------------------------------------------------------
    logic                  f_req_valid, f_req_ready, f_rsp_valid;   // Fetch to arbiter
    mem_req_t              f_req;
    mem_rsp_t              f_rsp;
    logic                  e_req_valid, e_req_ready, e_rsp_valid;   // Execute to arbiter
    mem_req_t              e_req;
    mem_rsp_t              e_rsp;
    logic                  instr_valid, instr_ready;                // Instruction hand-off
    logic [DATA_W-1:0]     instr, instr_pc;
    logic                  redirect_valid;
    logic [DATA_W-1:0]     redirect_pc;
    logic [REG_ADDR_W-1:0] rs_addr, rt_addr, wr_addr;               // Register file
    logic [DATA_W-1:0]     rs_data, rt_data, wr_data;
    logic                  wr_en;

    fetch_unit #(.RESET_PC(RESET_PC)) u_fetch (
        .clock, .rst_n,
        .req_valid (f_req_valid), .req (f_req), .req_ready (f_req_ready),
        .rsp_valid (f_rsp_valid), .rsp (f_rsp),
        .instr_valid, .instr, .instr_pc, .instr_ready,
        .redirect_valid, .redirect_pc,
        .halted
    );

    exec_unit u_exec (
        .clock, .rst_n,
        .instr_valid, .instr, .instr_pc, .instr_ready,
        .redirect_valid, .redirect_pc,
        .req_valid (e_req_valid), .req (e_req), .req_ready (e_req_ready),
        .rsp_valid (e_rsp_valid), .rsp (e_rsp),
        .rs_addr, .rt_addr, .rs_data, .rt_data,
        .wr_en, .wr_addr, .wr_data,
        .halted
    );

    reg_file #(.NUM_REGS(NUM_REGS)) u_regs (
        .clock, .rst_n,
        .rs_addr, .rt_addr, .rs_data, .rt_data,
        .wr_en, .wr_addr, .wr_data
    );

    bus_arbiter u_arb (
        .clock, .rst_n,
        .f_req_valid, .f_req, .f_req_ready, .f_rsp_valid, .f_rsp,
        .e_req_valid, .e_req, .e_req_ready, .e_rsp_valid, .e_rsp,
        .mem_req_valid, .mem_req, .mem_req_ready, .mem_rsp_valid, .mem_rsp
    );

endmodule

`default_nettype wire

/* verilog/exec_unit.sv */
/*
 * Execute unit. Reads operands while it accepts an instruction, then runs the
 * ALU and writes back, or issues a load or store and waits for the response.
 * Taken branches and jumps redirect the fetch unit for one cycle.
 */
`timescale 1ns/10ps
`default_nettype none

module exec_unit
    import cpu_pkg::*;
(
    input  wire                    clock,
    input  wire                    rst_n,
    input  wire                    instr_valid,
    input  wire [DATA_W-1:0]       instr,
    input  wire [DATA_W-1:0]       instr_pc,
    output logic                   instr_ready,
    output logic                   redirect_valid,
    output logic [DATA_W-1:0]      redirect_pc,
    output logic                   req_valid,
    output mem_req_t               req,
    input  wire                    req_ready,
    input  wire                    rsp_valid,
    input  wire mem_rsp_t          rsp,
    output logic [REG_ADDR_W-1:0]  rs_addr,
    output logic [REG_ADDR_W-1:0]  rt_addr,
    input  wire [DATA_W-1:0]       rs_data,
    input  wire [DATA_W-1:0]       rt_data,
    output logic                   wr_en,
    output logic [REG_ADDR_W-1:0]  wr_addr,
    output logic [DATA_W-1:0]      wr_data,
    output logic                   halted
);

    typedef enum logic [1:0] {IDLE, EXECUTE, MEM_WAIT, HALT} state_e;

    state_e            state;
    logic [DATA_W-1:0] ir;          // Accepted instruction
    logic [DATA_W-1:0] ir_pc;
    logic [DATA_W-1:0] op_a;        // rs value
    logic [DATA_W-1:0] op_b;        // rt value, or rd for sw and bne
    opcode_e           in_op;
    opcode_e           opc;
    logic [DATA_W-1:0] imm;
    logic [DATA_W-1:0] alu_b;
    logic [DATA_W-1:0] alu_res;
    alu_op_e           alu_op;
    logic              not_equal;
    logic              is_mem;
    logic              is_alu;

    // ------------------------------------------------------------------------
    // Decode and register read, in the accept cycle
    // ------------------------------------------------------------------------
    assign instr_ready = (state == IDLE);
    assign in_op       = get_opcode(instr);
    assign rs_addr     = get_reg(instr, RS_LSB);
    assign rt_addr     = (in_op == OP_SW || in_op == OP_BNE) ? get_reg(instr, RD_LSB)
                                                             : get_reg(instr, RT_LSB);

    always_ff @(posedge clock) begin
        if (instr_valid && instr_ready) begin
            ir    <= instr;
            ir_pc <= instr_pc;
            op_a  <= rs_data;
            op_b  <= rt_data;
        end
    end

    // ------------------------------------------------------------------------
    // Execute
    // ------------------------------------------------------------------------
    assign opc    = get_opcode(ir);
    assign imm    = sext_imm(ir);
    assign is_mem = (opc == OP_LW) || (opc == OP_SW);
    assign is_alu = opc inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_ADDI};
    assign alu_b  = (is_mem || opc == OP_ADDI) ? imm : op_b;

    always_comb begin
        case (opc)
            OP_SUB:  alu_op = ALU_SUB;
            OP_AND:  alu_op = ALU_AND;
            OP_OR:   alu_op = ALU_OR;
            default: alu_op = ALU_ADD;     // add, addi, address calc
        endcase
    end

    alu u_alu (
        .a         (op_a),
        .b         (alu_b),
        .op        (alu_op),
        .result    (alu_res),
        .not_equal (not_equal)
    );

    // Taken bne goes to pc+1+imm, j to the target field
    assign redirect_valid = (state == EXECUTE)
                          && ((opc == OP_BNE && not_equal) || opc == OP_J);
    assign redirect_pc    = (opc == OP_J) ? zext_target(ir) : ir_pc + 1 + imm;

    // Load or store, held until the arbiter takes it
    assign req_valid = (state == EXECUTE) && is_mem;
    assign req       = '{addr: alu_res, wdata: op_b, we: (opc == OP_SW)};

    // Writeback
    assign wr_en   = ((state == EXECUTE) && is_alu)
                   || ((state == MEM_WAIT) && rsp_valid && opc == OP_LW);
    assign wr_addr = get_reg(ir, RD_LSB);
    assign wr_data = (state == MEM_WAIT) ? rsp.rdata : alu_res;
    assign halted  = (state == HALT);

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (instr_valid) begin
                        state <= EXECUTE;
                    end
                end
                EXECUTE: begin
                    if (opc == OP_HALT) begin
                        state <= HALT;
                    end else if (!is_mem) begin
                        state <= IDLE;          // ALU, branch, jump or nop
                    end else if (req_ready) begin
                        state <= MEM_WAIT;
                    end
                end
                MEM_WAIT: begin
                    if (rsp_valid) begin
                        state <= IDLE;
                    end
                end
                HALT: state <= HALT;            // Only reset leaves
            endcase
        end
    end

endmodule

`default_nettype wire

/* verilog/fetch_unit.sv */
/*
 * Instruction fetch. Keeps the PC and a one-entry prefetch buffer and fetches
 * the next word over its bus channel while the buffer frees up. A redirect
 * from execute empties the buffer and drops any fetch still in flight.
 */
`timescale 1ns/10ps
`default_nettype none

module fetch_unit
    import cpu_pkg::*;
#(
    parameter logic [DATA_W-1:0] RESET_PC = '0
) (
    input  wire                clock,
    input  wire                rst_n,
    output logic               req_valid,
    output mem_req_t           req,
    input  wire                req_ready,
    input  wire                rsp_valid,
    input  wire mem_rsp_t      rsp,
    output logic               instr_valid,
    output logic [DATA_W-1:0]  instr,
    output logic [DATA_W-1:0]  instr_pc,
    input  wire                instr_ready,
    input  wire                redirect_valid,
    input  wire [DATA_W-1:0]   redirect_pc,
    input  wire                halted
);

    logic              req_on;      // Request waiting on the arbiter
    logic              in_flight;   // Accepted, response pending
    logic              discard;     // Pending response is off the old path
    logic              stopped;     // Halt handed over
    logic              buf_valid;
    logic [DATA_W-1:0] pc;          // Next word to fetch
    logic [DATA_W-1:0] req_addr;
    logic [DATA_W-1:0] buf_instr;
    logic [DATA_W-1:0] buf_pc;
    logic              take;
    logic              issue;

    // ------------------------------------------------------------------------
    // Issue when the buffer will be free, never past a halt
    // ------------------------------------------------------------------------
    assign take  = buf_valid & instr_ready;
    assign issue = ~req_on & ~in_flight & ~stopped & ~halted & ~redirect_valid
                 & (~buf_valid | take)
                 & ~(take & (get_opcode(buf_instr) == OP_HALT));

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            pc        <= RESET_PC;
            req_on    <= 1'b0;
            in_flight <= 1'b0;
            discard   <= 1'b0;
            stopped   <= 1'b0;
            buf_valid <= 1'b0;
        end else begin
            if (redirect_valid) begin
                pc <= redirect_pc;
            end else if (issue) begin
                pc <= pc + 1;
            end

            if (issue) begin
                req_on <= 1'b1;
            end else if (req_on && req_ready) begin
                req_on    <= 1'b0;
                in_flight <= 1'b1;
            end
            if (rsp_valid) begin
                in_flight <= 1'b0;
            end

            // Mark whatever is still out there as stale
            if (redirect_valid) begin
                discard <= req_on | (in_flight & ~rsp_valid);
            end else if (rsp_valid) begin
                discard <= 1'b0;
            end

            if (redirect_valid || take) begin
                buf_valid <= 1'b0;
            end else if (rsp_valid && !discard) begin
                buf_valid <= 1'b1;
            end

            if (take && get_opcode(buf_instr) == OP_HALT) begin
                stopped <= 1'b1;                // Until reset
            end
        end
    end

    // Fetch payload
    always_ff @(posedge clock) begin
        if (issue) begin
            req_addr <= pc;
        end
        if (rsp_valid && !discard && !redirect_valid) begin
            buf_instr <= rsp.rdata;
            buf_pc    <= req_addr;
        end
    end

    assign req_valid   = req_on;
    assign req         = '{addr: req_addr, wdata: '0, we: 1'b0};   // Reads only
    assign instr_valid = buf_valid;
    assign instr       = buf_instr;
    assign instr_pc    = buf_pc;

endmodule

`default_nettype wire

/* verilog/bus_arbiter.sv */
/*
 * Shares the external memory bus between the fetch and execute units.
 * Execute has fixed priority, one access is outstanding at a time and each
 * response goes back to the unit that owned the request.
 */
`timescale 1ns/10ps
`default_nettype none

module bus_arbiter
    import cpu_pkg::*;
(
    input  wire             clock,
    input  wire             rst_n,
    // Fetch channel
    input  wire             f_req_valid,
    input  wire mem_req_t   f_req,
    output logic            f_req_ready,
    output logic            f_rsp_valid,
    output mem_rsp_t        f_rsp,
    // Execute channel
    input  wire             e_req_valid,
    input  wire mem_req_t   e_req,
    output logic            e_req_ready,
    output logic            e_rsp_valid,
    output mem_rsp_t        e_rsp,
    // External bus
    output logic            mem_req_valid,
    output mem_req_t        mem_req,
    input  wire             mem_req_ready,
    input  wire             mem_rsp_valid,
    input  wire mem_rsp_t   mem_rsp
);

    logic busy;        // Accepted, waiting for the response
    logic owner_e;     // Owner of the outstanding access
    logic lock;        // Request stalled last cycle
    logic lock_e;      // Grant held while stalled
    logic grant_e;

    // Keep the grant fixed under back-pressure so the bus request holds
    assign grant_e = lock ? lock_e : e_req_valid;

    assign mem_req_valid = ~busy & (grant_e ? e_req_valid : f_req_valid);
    assign mem_req       = grant_e ? e_req : f_req;
    assign e_req_ready   = ~busy &  grant_e & mem_req_ready;
    assign f_req_ready   = ~busy & ~grant_e & mem_req_ready;

    // Response steering by owner
    assign e_rsp_valid = mem_rsp_valid &  owner_e;
    assign f_rsp_valid = mem_rsp_valid & ~owner_e;
    assign e_rsp       = mem_rsp;
    assign f_rsp       = mem_rsp;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            busy    <= 1'b0;
            owner_e <= 1'b0;
            lock    <= 1'b0;
            lock_e  <= 1'b0;
        end else begin
            if (mem_req_valid && mem_req_ready) begin
                busy    <= 1'b1;
                owner_e <= grant_e;
            end else if (mem_rsp_valid) begin
                busy    <= 1'b0;                // Bus free again next cycle
            end
            lock   <= mem_req_valid & ~mem_req_ready;
            lock_e <= grant_e;
        end
    end

endmodule

`default_nettype wire

/* verilog/reg_file.sv */
/*
 * Register file with two asynchronous read ports and one write port.
 * Register 0 reads as zero and drops writes.
 */
`timescale 1ns/10ps
`default_nettype none

module reg_file
    import cpu_pkg::*;
#(
    parameter int NUM_REGS = 32
) (
    input  wire                   clock,
    input  wire                   rst_n,
    input  wire [REG_ADDR_W-1:0]  rs_addr,
    input  wire [REG_ADDR_W-1:0]  rt_addr,
    output logic [DATA_W-1:0]     rs_data,
    output logic [DATA_W-1:0]     rt_data,
    input  wire                   wr_en,
    input  wire [REG_ADDR_W-1:0]  wr_addr,
    input  wire [DATA_W-1:0]      wr_data
);

    logic [DATA_W-1:0] regs [NUM_REGS];

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_addr != '0 && int'(wr_addr) < NUM_REGS) begin
            regs[wr_addr] <= wr_data;           // r0 never written
        end
    end

    // Out of range indexes read as zero
    assign rs_data = (rs_addr != '0 && int'(rs_addr) < NUM_REGS) ? regs[rs_addr] : '0;
    assign rt_data = (rt_addr != '0 && int'(rt_addr) < NUM_REGS) ? regs[rt_addr] : '0;

endmodule

`default_nettype wire

/* verilog/alu.sv */
/*
 * Combinational ALU of the execute unit. Wrapping add and subtract, bitwise
 * AND and OR, plus an inequality flag for bne.
 */
`timescale 1ns/10ps
`default_nettype none

module alu
    import cpu_pkg::*;
(
    input  wire [DATA_W-1:0]  a,           // rs operand
    input  wire [DATA_W-1:0]  b,           // rt, rd or immediate
    input  wire alu_op_e      op,
    output logic [DATA_W-1:0] result,
    output logic              not_equal    // Branch condition
);

    always_comb begin
        unique case (op)
            ALU_ADD: result = a + b;       // Wraps at 32 bits
            ALU_SUB: result = a - b;
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;
        endcase
    end

    assign not_equal = (a != b);

endmodule

`default_nettype wire

/* verilog/cpu_pkg.sv */
/*
 * Shared definitions for the word-addressed core. Holds the widths, the opcode
 * and ALU enums, the instruction field helpers and the memory bus structs.
 * Design modules take what they need through a wildcard import.
 */
`default_nettype none

package cpu_pkg;

    localparam int DATA_W     = 32;    // Data and word address width
    localparam int REG_ADDR_W = 5;     // Register index width

    // Instruction field positions
    localparam int OPC_LSB = 27;       // Opcode in bits 31..27
    localparam int OPC_W   = 5;
    localparam int RD_LSB  = 22;       // rd in bits 26..22
    localparam int RS_LSB  = 17;       // rs in bits 21..17
    localparam int RT_LSB  = 12;       // rt in bits 16..12
    localparam int IMM_W   = 17;       // Immediate in bits 16..0
    localparam int TGT_W   = 27;       // Jump target in bits 26..0

    // Kept opcodes, anything else runs as a nop
    typedef enum logic [OPC_W-1:0] {
        OP_ADD  = 5'b00000,
        OP_J    = 5'b00001,
        OP_BNE  = 5'b00010,
        OP_ADDI = 5'b00101,
        OP_SW   = 5'b00111,
        OP_LW   = 5'b01000,
        OP_SUB  = 5'b10000,
        OP_AND  = 5'b10001,
        OP_OR   = 5'b10010,
        OP_HALT = 5'b11111
    } opcode_e;

    typedef enum logic [1:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR
    } alu_op_e;

    // ------------------------------------------------------------------------
    // Field helpers
    // ------------------------------------------------------------------------
    function automatic opcode_e get_opcode(input logic [DATA_W-1:0] instr);
        return opcode_e'(instr[OPC_LSB +: OPC_W]);
    endfunction

    function automatic logic [REG_ADDR_W-1:0] get_reg(input logic [DATA_W-1:0] instr,
                                                      input int lsb);
        return instr[lsb +: REG_ADDR_W];   // rd, rs or rt by field position
    endfunction

    function automatic logic [DATA_W-1:0] sext_imm(input logic [DATA_W-1:0] instr);
        return {{(DATA_W-IMM_W){instr[IMM_W-1]}}, instr[IMM_W-1:0]};
    endfunction

    function automatic logic [DATA_W-1:0] zext_target(input logic [DATA_W-1:0] instr);
        return {{(DATA_W-TGT_W){1'b0}}, instr[TGT_W-1:0]};
    endfunction

    // Memory bus payloads
    typedef struct packed {
        logic [DATA_W-1:0] addr;    // Word address
        logic [DATA_W-1:0] wdata;   // Store data
        logic              we;      // Write enable
    } mem_req_t;

    typedef struct packed {
        logic [DATA_W-1:0] rdata;   // Read data, don't care after a write
    } mem_rsp_t;

endpackage

`default_nettype wire
